// File: src/dzPkg.sv
// Shared constants and types for the eight-line DZ-style terminal multiplexer
package dzPkg;

   ////////////////////
   // Lines
   ////////////////////

   // Number of serial lines
   localparam int numLines = 8;

   // Line number, wraps naturally at numLines
   typedef logic [$clog2(numLines)-1:0] lineIndex_t;

   ////////////////////
   // Register port
   ////////////////////

   typedef logic [15:0] regWord_t;
   typedef logic [1:0]  regIndex_t;

   // Word indices
   localparam regIndex_t csrIndex  = 2'd0;
   localparam regIndex_t rbufIndex = 2'd1;
   localparam regIndex_t tcrIndex  = 2'd2;
   localparam regIndex_t tdrIndex  = 2'd3;

   // CSR bit positions
   localparam int csrMaintBit   = 3;
   localparam int csrClrBit     = 4;
   localparam int csrMseBit     = 5;
   localparam int csrRdoneBit   = 7;
   localparam int csrTlineLsb   = 8;
   localparam int csrTlineWidth = 3;
   localparam int csrTrdyBit    = 15;

   // RBUF word layout
   localparam int rbufValidBit = 15;
   localparam int rbufLineLsb  = 8;

   ////////////////////
   // Serial timing and silo
   ////////////////////

   // Clocks per serial bit
   localparam int bitTicks = 16;

   // Start, eight data bits, stop
   localparam int frameBits = 10;

   // Receive silo entries
   localparam int siloDepth   = 8;
   localparam int siloPtrBits = $clog2(siloDepth);

endpackage

// File: src/dzRegisters.sv
// DZ register block: index decode, CSR and TCR storage, clear pulse and read mux
`timescale 1ns/1ps

module dzRegisters (
   input  logic                        clk,
   input  logic                        reset,
   input  dzPkg::regIndex_t            regAddr,
   input  logic                        regRead,
   input  logic                        regWrite,
   input  dzPkg::regWord_t             wrData,
   input  logic                        txReady,
   input  dzPkg::lineIndex_t           txLine,
   input  logic                        rdone,
   input  dzPkg::regWord_t             rbufWord,
   output dzPkg::regWord_t             rdData,
   output logic                        ack,
   output logic                        maint,
   output logic                        scanEnable,
   output logic [dzPkg::numLines-1:0]  lineEnable,
   output logic                        tdrLoad,
   output logic [7:0]                  tdrChar,
   output logic                        rbufPop,
   output logic                        init
);

   import dzPkg::*;

   // Write decode
   logic     csrWrite;
   logic     tcrWrite;
   logic     tdrWrite;
   logic     clearReq;

   // Assembled CSR read word
   regWord_t csrWord;

   ////////////////////
   // Decode
   ////////////////////

   assign csrWrite = regWrite & (regAddr == csrIndex);
   assign tcrWrite = regWrite & (regAddr == tcrIndex);
   assign tdrWrite = regWrite & (regAddr == tdrIndex);

   // Every index exists, so every strobe is acknowledged
   assign ack = regRead | regWrite;

   // CSR write with CLR set
   assign clearReq = csrWrite & wrData[csrClrBit];

   // Each RBUF read drops the silo head
   assign rbufPop = regRead & (regAddr == rbufIndex);

   // Character only handed over while a line is offered
   assign tdrLoad = tdrWrite & txReady;

   ////////////////////
   // Storage
   ////////////////////

   // One-cycle master clear, one edge after the CSR write
   always_ff @(posedge clk)
   begin
      if (reset)
         init <= 1'b0;
      else
         init <= clearReq;
   end

   // MAINT and MSE
   // A clearing write already zeroes them, init keeps them zero
   always_ff @(posedge clk)
   begin
      if (reset || init || clearReq)
      begin
         maint      <= 1'b0;
         scanEnable <= 1'b0;
      end
      else if (csrWrite)
      begin
         maint      <= wrData[csrMaintBit];
         scanEnable <= wrData[csrMseBit];
      end
   end

   // TCR line-enable byte
   always_ff @(posedge clk)
   begin
      if (reset || init || clearReq)
         lineEnable <= '0;
      else if (tcrWrite)
         lineEnable <= wrData[numLines-1:0];
   end

   // TDR character, held until the line loads it one edge later
   always_ff @(posedge clk)
   begin
      if (tdrWrite)
         tdrChar <= wrData[7:0];
   end

   ////////////////////
   // Read path
   ////////////////////

   // CSR word; CLR always reads 0
   always_comb
   begin
      csrWord              = '0;
      csrWord[csrMaintBit] = maint;
      csrWord[csrMseBit]   = scanEnable;
      csrWord[csrRdoneBit] = rdone;
      csrWord[csrTrdyBit]  = txReady;
      // TLINE only meaningful while TRDY, scan pointer hidden otherwise
      if (txReady)
         csrWord[csrTlineLsb +: csrTlineWidth] = txLine;
   end

   // Read mux, zero outside a read strobe
   always_comb
   begin
      rdData = '0;
      if (regRead)
      begin
         case (regAddr)
            csrIndex:  rdData = csrWord;
            rbufIndex: rdData = rbufWord;
            tcrIndex:  rdData = regWord_t'(lineEnable);
            default:   rdData = '0;   // TDR is write-only
         endcase
      end
   end

endmodule

// File: src/dzTransmitScanner.sv
// DZ transmit scanner: round-robin search for a ready line and character hand-off
`timescale 1ns/1ps

module dzTransmitScanner (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        init,
   input  logic                        scanEnable,
   input  logic [dzPkg::numLines-1:0]  lineEnable,
   input  logic [dzPkg::numLines-1:0]  txEmpty,
   input  logic                        tdrLoad,
   output logic                        txReady,
   output dzPkg::lineIndex_t           txLine,
   output logic [dzPkg::numLines-1:0]  txLoad
);

   import dzPkg::*;

   // Scanner parked on txLine
   logic found;

   // Line under the pointer can take a character
   logic lineOk;

   assign lineOk = lineEnable[txLine] & txEmpty[txLine];

   // TRDY drops at once if MSE or the line's enable goes away
   assign txReady = found & scanEnable & lineEnable[txLine];

   ////////////////////
   // Scan pointer
   ////////////////////

   always_ff @(posedge clk)
   begin
      if (reset || init)
      begin
         found  <= 1'b0;
         txLine <= '0;
         txLoad <= '0;
      end
      else
      begin
         // Load strobes last one cycle
         txLoad <= '0;
         if (tdrLoad)
         begin
            // Hand the TDR character to this line, resume at the next one
            txLoad[txLine] <= 1'b1;
            found          <= 1'b0;
            txLine         <= txLine + 1'b1;
         end
         else if (found)
         begin
            // Offer withdrawn, search again from here
            if (!scanEnable || !lineEnable[txLine])
               found <= 1'b0;
         end
         else if (scanEnable)
         begin
            if (lineOk)
               found <= 1'b1;
            else
               txLine <= txLine + 1'b1;   // 3-bit pointer wraps 7 to 0
         end
      end
   end

endmodule

// File: src/dzReceiveScanner.sv
// DZ receive scanner: round-robin collection of characters into the RBUF silo
`timescale 1ns/1ps

module dzReceiveScanner (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        init,
   input  logic                        scanEnable,
   input  logic [dzPkg::numLines-1:0]  rxFull,
   input  logic [7:0]                  rxChar [dzPkg::numLines],
   input  logic                        rbufPop,
   output logic [dzPkg::numLines-1:0]  rxClear,
   output logic                        rdone,
   output dzPkg::regWord_t             rbufWord
);

   import dzPkg::*;

   // Silo entry, line number above the character
   typedef struct packed {
      lineIndex_t line;
      logic [7:0] data;
   } siloEntry_t;

   siloEntry_t             silo [siloDepth];
   siloEntry_t             siloHead;

   // Pointers carry one extra wrap bit for full/empty
   logic [siloPtrBits:0]   wrPtr;
   logic [siloPtrBits:0]   rdPtr;
   logic                   siloEmpty;
   logic                   siloFull;

   lineIndex_t             scanLine;
   logic                   push;
   logic                   pop;

   assign siloEmpty = (wrPtr == rdPtr);
   assign siloFull  = (wrPtr[siloPtrBits] != rdPtr[siloPtrBits]) &&
                      (wrPtr[siloPtrBits-1:0] == rdPtr[siloPtrBits-1:0]);

   // Capture the line under the pointer if it holds a character
   assign push = scanEnable & ~siloFull & rxFull[scanLine];
   assign pop  = rbufPop & ~siloEmpty;

   // Release the line's holding buffer on the capturing edge
   always_comb
   begin
      rxClear           = '0;
      rxClear[scanLine] = push;
   end

   ////////////////////
   // Scan and silo pointers
   ////////////////////

   // Full silo stalls the scan, characters wait in their lines
   always_ff @(posedge clk)
   begin
      if (reset || init)
         scanLine <= '0;
      else if (scanEnable && !siloFull)
         scanLine <= scanLine + 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (reset || init)
      begin
         wrPtr <= '0;
         rdPtr <= '0;
      end
      else
      begin
         if (push)
            wrPtr <= wrPtr + 1'b1;
         if (pop)
            rdPtr <= rdPtr + 1'b1;
      end
   end

   // Silo storage
   always_ff @(posedge clk)
   begin
      if (push)
         silo[wrPtr[siloPtrBits-1:0]] <= '{line: scanLine, data: rxChar[scanLine]};
   end

   ////////////////////
   // Read-out
   ////////////////////

   assign siloHead = silo[rdPtr[siloPtrBits-1:0]];
   assign rdone    = ~siloEmpty;

   // Head entry with valid flag, all zero when empty
   always_comb
   begin
      rbufWord = '0;
      if (!siloEmpty)
      begin
         rbufWord[rbufValidBit]                       = 1'b1;
         rbufWord[rbufLineLsb +: $bits(lineIndex_t)] = siloHead.line;
         rbufWord[7:0]                                = siloHead.data;
      end
   end

endmodule

// File: src/dzUart.sv
// DZ serial line: fixed 8N1 transmitter and receiver, one holding buffer each
`timescale 1ns/1ps

module dzUart (
   input  logic       clk,
   input  logic       reset,
   input  logic       init,
   input  logic       txLoad,
   input  logic [7:0] txChar,
   input  logic       rxd,
   input  logic       rxClear,
   output logic       txd,
   output logic       txEmpty,
   output logic       rxFull,
   output logic [7:0] rxChar
);

   import dzPkg::*;

   typedef logic [$clog2(bitTicks)-1:0]  tick_t;
   typedef logic [$clog2(frameBits+1)-1:0] bitCount_t;

   // Transmitter
   logic [frameBits-1:0] txShift;
   bitCount_t            txBits;
   tick_t                txTick;

   // Receiver
   logic                 rxMeta;
   logic                 rxSync;
   logic                 rxPrev;
   logic                 rxBusy;
   logic                 rxSample;
   tick_t                rxTick;
   bitCount_t            rxBits;
   logic [7:0]           rxShift;

   ////////////////////
   // Transmitter
   ////////////////////

   // Frame LSB drives the line, ones shift in behind it
   assign txd     = txShift[0];
   assign txEmpty = (txBits == '0);

   always_ff @(posedge clk)
   begin
      if (reset || init)
      begin
         txShift <= '1;
         txBits  <= '0;
         txTick  <= '0;
      end
      else if (txEmpty)
      begin
         // Stop, data LSB first, start
         if (txLoad)
         begin
            txShift <= {1'b1, txChar, 1'b0};
            txBits  <= bitCount_t'(frameBits);
            txTick  <= '0;
         end
      end
      else if (txTick == tick_t'(bitTicks - 1))
      begin
         txTick  <= '0;
         txShift <= {1'b1, txShift[frameBits-1:1]};
         txBits  <= txBits - 1'b1;
      end
      else
         txTick <= txTick + 1'b1;
   end

   ////////////////////
   // Receiver
   ////////////////////

   // Two-flop synchronizer plus edge history, idle high
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rxMeta <= 1'b1;
         rxSync <= 1'b1;
         rxPrev <= 1'b1;
      end
      else
      begin
         rxMeta <= rxd;
         rxSync <= rxMeta;
         rxPrev <= rxSync;
      end
   end

   // Mid-bit sample point
   assign rxSample = rxBusy && (rxTick == tick_t'(bitTicks - 1));

   always_ff @(posedge clk)
   begin
      if (reset || init)
      begin
         rxBusy <= 1'b0;
         rxTick <= '0;
         rxBits <= '0;
         rxFull <= 1'b0;
      end
      else
      begin
         if (rxClear)
            rxFull <= 1'b0;
         if (!rxBusy)
         begin
            // Falling start edge, first sample half a bit later
            if (rxPrev && !rxSync)
            begin
               rxBusy <= 1'b1;
               rxTick <= tick_t'(bitTicks / 2);
               rxBits <= '0;
            end
         end
         else if (rxSample)
         begin
            rxTick <= '0;
            rxBits <= rxBits + 1'b1;
            if (rxBits == '0 && rxSync)
               rxBusy <= 1'b0;   // glitch, not a start bit
            else if (rxBits == bitCount_t'(frameBits - 1))
            begin
               rxBusy <= 1'b0;
               // Bad stop bit drops the frame; new frame overwrites
               if (rxSync)
                  rxFull <= 1'b1;
            end
         end
         else
            rxTick <= rxTick + 1'b1;
      end
   end

   // Data bits shift in LSB first, buffer loads on a good stop bit
   always_ff @(posedge clk)
   begin
      if (rxSample && rxBits != '0 && rxBits != bitCount_t'(frameBits - 1))
         rxShift <= {rxSync, rxShift[7:1]};
      if (rxSample && rxBits == bitCount_t'(frameBits - 1) && rxSync)
         rxChar <= rxShift;
   end

endmodule

// File: src/dzMux.sv
// Eight-line DZ-style terminal multiplexer top level
`timescale 1ns/1ps

module dzMux (
   input  logic                        clk,
   input  logic                        reset,
   input  dzPkg::regIndex_t            regAddr,
   input  logic                        regRead,
   input  logic                        regWrite,
   input  dzPkg::regWord_t             wrData,
   output dzPkg::regWord_t             rdData,
   output logic                        ack,
   input  logic [dzPkg::numLines-1:0]  rxd,
   output logic [dzPkg::numLines-1:0]  txd
);

   import dzPkg::*;

   // Register block controls
   logic                maint;
   logic                scanEnable;
   logic [numLines-1:0] lineEnable;
   logic                tdrLoad;
   logic [7:0]          tdrChar;
   logic                rbufPop;
   logic                init;

   // Scanner status
   logic                txReady;
   lineIndex_t          txLine;
   logic                rdone;
   regWord_t            rbufWord;

   // Per-line handshakes
   logic [numLines-1:0] txLoad;
   logic [numLines-1:0] txEmpty;
   logic [numLines-1:0] rxFull;
   logic [numLines-1:0] rxClear;
   logic [7:0]          rxChar [numLines];

   // Receiver inputs after loopback select
   logic [numLines-1:0] lineRxd;

   ////////////////////
   // Control
   ////////////////////

   dzRegisters u_registers (
      .clk        (clk),
      .reset      (reset),
      .regAddr    (regAddr),
      .regRead    (regRead),
      .regWrite   (regWrite),
      .wrData     (wrData),
      .txReady    (txReady),
      .txLine     (txLine),
      .rdone      (rdone),
      .rbufWord   (rbufWord),
      .rdData     (rdData),
      .ack        (ack),
      .maint      (maint),
      .scanEnable (scanEnable),
      .lineEnable (lineEnable),
      .tdrLoad    (tdrLoad),
      .tdrChar    (tdrChar),
      .rbufPop    (rbufPop),
      .init       (init)
   );

   dzTransmitScanner u_txScanner (
      .clk        (clk),
      .reset      (reset),
      .init       (init),
      .scanEnable (scanEnable),
      .lineEnable (lineEnable),
      .txEmpty    (txEmpty),
      .tdrLoad    (tdrLoad),
      .txReady    (txReady),
      .txLine     (txLine),
      .txLoad     (txLoad)
   );

   dzReceiveScanner u_rxScanner (
      .clk        (clk),
      .reset      (reset),
      .init       (init),
      .scanEnable (scanEnable),
      .rxFull     (rxFull),
      .rxChar     (rxChar),
      .rbufPop    (rbufPop),
      .rxClear    (rxClear),
      .rdone      (rdone),
      .rbufWord   (rbufWord)
   );

   ////////////////////
   // Lines
   ////////////////////

   // Maintenance mode turns each transmitter back into its own receiver
   assign lineRxd = maint ? txd : rxd;

   for (genvar i = 0; i < numLines; i++)
   begin : gLine
      dzUart u_line (
         .clk     (clk),
         .reset   (reset),
         .init    (init),
         .txLoad  (txLoad[i]),
         .txChar  (tdrChar),
         .rxd     (lineRxd[i]),
         .rxClear (rxClear[i]),
         .txd     (txd[i]),
         .txEmpty (txEmpty[i]),
         .rxFull  (rxFull[i]),
         .rxChar  (rxChar[i])
      );
   end

endmodule

// File: bench/dzMux_properties.sv
// DZ multiplexer bound checks on register-port strobes and transmit scanner offers
`timescale 1ns/1ps

module dzMuxProperties (
   input logic                        clk,
   input logic                        reset,
   input dzPkg::regIndex_t            regAddr,
   input logic                        regRead,
   input logic                        regWrite,
   input dzPkg::regWord_t             rdData,
   input logic                        ack,
   input logic [dzPkg::numLines-1:0]  lineEnable
);

   import dzPkg::*;

   ////////////////////
   // Register port
   ////////////////////

   // Acknowledge only answers a strobe
   ackOnlyOnStrobe: assert property (@(posedge clk) disable iff (reset)
      ack |-> (regRead || regWrite))
      else $error("ack raised without a read or write strobe");

   // One strobe at a time
   strobesExclusive: assert property (@(posedge clk) disable iff (reset)
      !(regRead && regWrite))
      else $error("read and write strobes high together");

   ////////////////////
   // Transmit scanner
   ////////////////////

   // A CSR read that offers TRDY names a line enabled in TCR
   trdyOnEnabledLine: assert property (@(posedge clk) disable iff (reset)
      (regRead && regAddr == csrIndex && rdData[csrTrdyBit])
         |-> lineEnable[rdData[csrTlineLsb +: csrTlineWidth]])
      else $error("CSR read offers TRDY on a line that TCR does not enable");

endmodule

// File: bench/dzMuxTb.sv
// DZ multiplexer testbench: register and serial drivers, reference model and checks
`timescale 1ns/1ps

module dzMuxTb;

   import dzPkg::*;

   logic                clk;
   logic                reset;
   regIndex_t           regAddr;
   logic                regRead;
   logic                regWrite;
   regWord_t            wrData;
   regWord_t            rdData;
   logic                ack;
   logic [numLines-1:0] rxd;
   logic [numLines-1:0] txd;

   // Expected read data, consumed by the checker at each checked read
   regWord_t            expQ [$];
   regWord_t            expected;
   logic                checkNow;
   logic [31:0]         lfsrState;

   dzMux u_dut (
      .clk      (clk),
      .reset    (reset),
      .regAddr  (regAddr),
      .regRead  (regRead),
      .regWrite (regWrite),
      .wrData   (wrData),
      .rdData   (rdData),
      .ack      (ack),
      .rxd      (rxd),
      .txd      (txd)
   );

   bind dzMux dzMuxProperties u_props (
      .clk        (clk),
      .reset      (reset),
      .regAddr    (regAddr),
      .regRead    (regRead),
      .regWrite   (regWrite),
      .rdData     (rdData),
      .ack        (ack),
      .lineEnable (lineEnable)
   );

   always #5 clk = ~clk;

   ////////////////////
   // Helpers
   ////////////////////

   task automatic stopRun(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1);
   endtask

   // Galois LFSR, one step per bit taken
   function automatic logic [7:0] randomBits(input int count);
      logic [7:0] v;
      v = '0;
      for (int i = 0; i < count; i++)
      begin
         lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'h80200003 : lfsrState >> 1;
         v = {v[6:0], lfsrState[0]};
      end
      return v;
   endfunction

   // Reference RBUF word: valid, line number, character
   function automatic regWord_t expectRbuf(input lineIndex_t line, input logic [7:0] ch);
      return {1'b1, 4'b0000, line, ch};
   endfunction

   // Reference CSR word, TLINE passed as 0 while TRDY is clear
   function automatic regWord_t expectCsr(input logic maint, input logic mse,
                                          input logic rdone, input logic trdy,
                                          input lineIndex_t tline);
      regWord_t w;
      w = '0;
      w[csrMaintBit] = maint;
      w[csrMseBit] = mse;
      w[csrRdoneBit] = rdone;
      w[csrTrdyBit] = trdy;
      w[csrTlineLsb +: csrTlineWidth] = tline;
      return w;
   endfunction

   function automatic regWord_t csrWriteWord(input logic maint, input logic mse,
                                             input logic clr);
      regWord_t w;
      w = '0;
      w[csrMaintBit] = maint;
      w[csrMseBit] = mse;
      w[csrClrBit] = clr;
      return w;
   endfunction

   // First enabled line at or after start, round robin
   function automatic lineIndex_t nextEnabled(input logic [7:0] mask, input lineIndex_t start);
      lineIndex_t l;
      lineIndex_t hit;
      logic       found;
      l = start;
      hit = start;
      found = 1'b0;
      for (int i = 0; i < numLines; i++)
      begin
         if (!found && mask[l])
         begin
            hit = l;
            found = 1'b1;
         end
         l = l + 1'b1;
      end
      return hit;
   endfunction

   ////////////////////
   // Bus and serial drivers
   ////////////////////

   // Strobes start 1 ns after an edge and last one cycle
   task automatic busWrite(input regIndex_t idx, input regWord_t data);
      regAddr = idx;
      wrData = data;
      regWrite = 1'b1;
      @(posedge clk);
      #1;
      regWrite = 1'b0;
   endtask

   task automatic busRead(input regIndex_t idx, output regWord_t data);
      regAddr = idx;
      regRead = 1'b1;
      @(negedge clk);
      data = rdData;
      @(posedge clk);
      #1;
      regRead = 1'b0;
   endtask

   task automatic checkRead(input regIndex_t idx, input regWord_t exp);
      regWord_t unused;
      expQ.push_back(exp);
      checkNow = 1'b1;
      busRead(idx, unused);
      checkNow = 1'b0;
   endtask

   // CSR clear, then one cycle for the init pulse that follows it
   task automatic masterClear();
      busWrite(csrIndex, csrWriteWord(1'b0, 1'b0, 1'b1));
      @(posedge clk);
      #1;
   endtask

   // Poll CSR until one bit is set
   task automatic waitCsrBit(input int bitPos, input string what, output regWord_t w);
      int n;
      int pollLimit;
      n = 0;
      pollLimit = bitTicks * frameBits * 2;
      w = '0;
      while (!w[bitPos])
      begin
         if (n == pollLimit)
            stopRun($sformatf("Timed out waiting for %s in CSR", what));
         busRead(csrIndex, w);
         n++;
      end
   endtask

   // One 8N1 frame on an rxd line
   task automatic sendFrame(input lineIndex_t line, input logic [7:0] ch);
      logic [frameBits-1:0] frame;
      frame = {1'b1, ch, 1'b0};
      for (int b = 0; b < frameBits; b++)
      begin
         rxd[line] = frame[b];
         repeat (bitTicks)
         begin
            @(posedge clk);
            #1;
         end
      end
   endtask

   // Serial monitor, samples txd near each bit middle
   task automatic receiveFrame(input lineIndex_t line, input int limit, output logic [7:0] ch);
      int n;
      n = 0;
      ch = '0;
      @(negedge clk);
      while (txd[line] !== 1'b0)
      begin
         if (n == limit)
            stopRun($sformatf("No start bit on txd line %0d", line));
         @(negedge clk);
         n++;
      end
      repeat (bitTicks / 2 - 1) @(negedge clk);
      assert (txd[line] === 1'b0)
         else stopRun($sformatf("FAIL %0t: start bit on line %0d too short", $time, line));
      for (int b = 0; b < 8; b++)
      begin
         repeat (bitTicks) @(negedge clk);
         ch[b] = txd[line];
      end
      repeat (bitTicks) @(negedge clk);
      assert (txd[line] === 1'b1)
         else stopRun($sformatf("FAIL %0t: stop bit on line %0d is 0", $time, line));
      @(posedge clk);
      #1;
   endtask

   ////////////////////
   // Checker
   ////////////////////

   // Mid-cycle sampling, strobes and read data are settled here
   always @(negedge clk)
   begin
      if (!reset)
      begin
         assert (ack === (regRead | regWrite))
            else stopRun("ack did not follow the read or write strobe");
         if (regRead && checkNow)
         begin
            assert (expQ.size() > 0) else stopRun("Checked read with no expected value");
            expected = expQ.pop_front();
            assert (rdData === expected)
               else stopRun($sformatf("FAIL %0t: index %0d read %h, expected %h",
                                      $time, regAddr, rdData, expected));
         end
      end
   end

   ////////////////////
   // Stimulus
   ////////////////////

   initial
   begin
      lineIndex_t line;
      lineIndex_t expLine;
      logic [7:0] mask;
      logic [7:0] ch;
      logic [7:0] got;
      regWord_t   w;
      clk = 1'b0;
      reset = 1'b1;
      regAddr = csrIndex;
      regRead = 1'b0;
      regWrite = 1'b0;
      wrData = '0;
      rxd = '1;
      checkNow = 1'b0;
      lfsrState = 32'ha5ae6fed;
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;

      // Reset state, RBUF write and TDR read ignored
      assert (txd === 8'hff) else stopRun($sformatf("FAIL %0t: txd %h after reset", $time, txd));
      checkRead(csrIndex, '0);
      checkRead(rbufIndex, '0);
      checkRead(tcrIndex, '0);
      checkRead(tdrIndex, '0);
      busWrite(rbufIndex, 16'hffff);
      checkRead(rbufIndex, '0);

      // CSR and TCR storage, clear
      busWrite(csrIndex, csrWriteWord(1'b1, 1'b1, 1'b0));
      checkRead(csrIndex, expectCsr(1'b1, 1'b1, 1'b0, 1'b0, '0));
      mask = randomBits(8);
      busWrite(tcrIndex, {8'h00, mask});
      checkRead(tcrIndex, {8'h00, mask});
      busWrite(csrIndex, csrWriteWord(1'b1, 1'b1, 1'b1));
      checkRead(tcrIndex, '0);
      checkRead(csrIndex, '0);

      // Round-robin TLINE order
      mask = randomBits(8);
      if (mask == '0)
         mask = 8'h01;
      busWrite(tcrIndex, {8'h00, mask});
      busWrite(csrIndex, csrWriteWord(1'b0, 1'b1, 1'b0));
      expLine = nextEnabled(mask, '0);
      for (int i = 0; i < 3; i++)
      begin
         waitCsrBit(csrTrdyBit, "TRDY", w);
         line = w[csrTlineLsb +: csrTlineWidth];
         assert (line == expLine)
            else stopRun($sformatf("FAIL %0t: TLINE %0d, expected %0d", $time, line, expLine));
         checkRead(csrIndex, expectCsr(1'b0, 1'b1, 1'b0, 1'b1, expLine));
         busWrite(tdrIndex, {8'h00, randomBits(8)});
         expLine = nextEnabled(mask, expLine + 1'b1);
      end
      masterClear();

      // Loopback through each offered line
      mask = randomBits(8);
      if (mask == '0)
         mask = 8'h80;
      busWrite(tcrIndex, {8'h00, mask});
      busWrite(csrIndex, csrWriteWord(1'b1, 1'b1, 1'b0));
      expLine = nextEnabled(mask, '0);
      for (int i = 0; i < 4; i++)
      begin
         waitCsrBit(csrTrdyBit, "TRDY", w);
         line = w[csrTlineLsb +: csrTlineWidth];
         assert (line == expLine)
            else stopRun($sformatf("FAIL %0t: TLINE %0d, expected %0d", $time, line, expLine));
         ch = randomBits(8);
         busWrite(tdrIndex, {8'h00, ch});
         waitCsrBit(csrRdoneBit, "RDONE", w);
         checkRead(rbufIndex, expectRbuf(expLine, ch));
         busRead(csrIndex, w);
         assert (!w[csrRdoneBit])
            else stopRun($sformatf("FAIL %0t: RDONE still set after RBUF read", $time));
         checkRead(rbufIndex, '0);
         expLine = nextEnabled(mask, expLine + 1'b1);
      end

      // External rxd frame, then a TDR character out on txd
      masterClear();
      mask = randomBits(8) | 8'h01;
      busWrite(tcrIndex, {8'h00, mask});
      busWrite(csrIndex, csrWriteWord(1'b0, 1'b1, 1'b0));
      line = lineIndex_t'(randomBits(3));
      ch = randomBits(8);
      sendFrame(line, ch);
      waitCsrBit(csrRdoneBit, "RDONE", w);
      checkRead(rbufIndex, expectRbuf(line, ch));
      waitCsrBit(csrTrdyBit, "TRDY", w);
      line = w[csrTlineLsb +: csrTlineWidth];
      expLine = nextEnabled(mask, '0);
      assert (line == expLine)
         else stopRun($sformatf("FAIL %0t: TLINE %0d, expected %0d", $time, line, expLine));
      ch = randomBits(8);
      busWrite(tdrIndex, {8'h00, ch});
      receiveFrame(expLine, 2, got);
      assert (got == ch)
         else stopRun($sformatf("FAIL %0t: txd line %0d sent %h, expected %h",
                                $time, expLine, got, ch));

      $display("Simulation passed");
      $finish;
   end

endmodule

// File: dzMux.f
src/dzPkg.sv
src/dzRegisters.sv
src/dzTransmitScanner.sv
src/dzReceiveScanner.sv
src/dzUart.sv
src/dzMux.sv
bench/dzMux_properties.sv
bench/dzMuxTb.sv

// File: Makefile
# Verilator build and run for the DZ multiplexer testbench

TOP = dzMuxTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f dzMux.f

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -Wall --top-module dzMux -f dzMux.f

clean:
	rm -rf obj_dir
